// ==== common/ddr2_pkg.sv ====
package ddr2_pkg;

	//////////////////////////////////////////////////
	// shared widths and margins
	//////////////////////////////////////////////////

	// cache-side ddr2 address, one word
	parameter int ADDR_WIDTH = 31;

	// free slots left when an almost-full flag rises
	// two covers both pushes of one accepted write
	parameter int AF_AFULL_MARGIN = 2;

	//////////////////////////////////////////////////
	// address fifo command encoding
	//////////////////////////////////////////////////

	// mig user interface codes, 3 bits wide
	typedef enum logic [2:0]
	{
		CMD_WRITE = 3'd0,
		CMD_READ  = 3'd1
	} mig_cmd_t;

	// one address fifo entry
	typedef struct packed
	{
		mig_cmd_t               cmd;
		logic [ADDR_WIDTH-1:0]  addr;
	} af_entry_t;

endpackage

// ==== common/mig_user_if.sv ====
`timescale 1ns/1ps

interface mig_user_if #(
	parameter int APPDATA_WIDTH = 128
);

	// address fifo push side
	logic                             af_wren;
	ddr2_pkg::mig_cmd_t               af_cmd;
	logic [ddr2_pkg::ADDR_WIDTH-1:0]  af_addr;
	logic                             af_afull;

	// write data fifo push side
	logic                             wdf_wren;
	logic [APPDATA_WIDTH-1:0]         wdf_data;
	logic                             wdf_afull;

	// read return, no back-pressure
	logic                             rd_data_valid;
	logic [APPDATA_WIDTH-1:0]         rd_data;

	// line port side
	modport ctrl
	(
		output af_wren,
		output af_cmd,
		output af_addr,
		input  af_afull,
		output wdf_wren,
		output wdf_data,
		input  wdf_afull,
		input  rd_data_valid,
		input  rd_data
	);

	// memory controller side
	modport mem
	(
		input  af_wren,
		input  af_cmd,
		input  af_addr,
		output af_afull,
		input  wdf_wren,
		input  wdf_data,
		output wdf_afull,
		output rd_data_valid,
		output rd_data
	);

endinterface

// ==== line_port/line_port.sv ====
`timescale 1ns/1ps

module line_port #(
	parameter int APPDATA_WIDTH = 128,
	parameter int WR_SETTLE     = 5
)
(
	input  logic                             clk,
	input  logic                             rst,

	// cache side strobes and payload
	input  logic                             data_wren,
	input  logic                             data_rden,
	input  logic [2*APPDATA_WIDTH-1:0]       data_wr,
	input  logic [ddr2_pkg::ADDR_WIDTH-1:0]  data_addr,

	// cache side status and read line
	output logic                             mc_wr_rdy,
	output logic                             mc_rd_rdy,
	output logic                             mc_rd_valid,
	output logic [2*APPDATA_WIDTH-1:0]       data_rd,

	// mig user side
	mig_user_if.ctrl                         mig
);

	localparam int SETTLE_W = $clog2(WR_SETTLE + 1);

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_WR_BEAT0,
		ST_WR_BEAT1,
		ST_SETTLE,
		ST_RD_ISSUE,
		ST_RD_WAIT
	} state_t;

	state_t                           state;
	logic [SETTLE_W-1:0]              settle_cnt;
	logic                             beat0_valid;

	// captured request, held until the beats are out
	logic [1:0][APPDATA_WIDTH-1:0]    line_q;
	logic [ddr2_pkg::ADDR_WIDTH-1:0]  addr_q;

	// low half of a read, kept until the high half arrives
	logic [APPDATA_WIDTH-1:0]         beat0_q;

	logic                             idle;
	logic                             wr_accept;
	logic                             rd_accept;

	//////////////////////////////////////////////////
	// readiness and acceptance
	//////////////////////////////////////////////////

	assign idle      = (state == ST_IDLE);

	// write needs room in both fifos, read only in the address fifo
	assign mc_wr_rdy = idle && !mig.af_afull && !mig.wdf_afull;
	assign mc_rd_rdy = idle && !mig.af_afull;

	// write wins when both strobes are up
	assign wr_accept = data_wren && mc_wr_rdy;
	assign rd_accept = data_rden && mc_rd_rdy && !data_wren;

	//////////////////////////////////////////////////
	// mig pushes, decoded from state
	//////////////////////////////////////////////////

	// one command per request
	assign mig.af_wren  = (state == ST_WR_BEAT0) || (state == ST_RD_ISSUE);
	assign mig.af_cmd   = (state == ST_RD_ISSUE) ? ddr2_pkg::CMD_READ : ddr2_pkg::CMD_WRITE;
	assign mig.af_addr  = addr_q;

	// low half goes with the command, high half one cycle later
	assign mig.wdf_wren = (state == ST_WR_BEAT0) || (state == ST_WR_BEAT1);
	assign mig.wdf_data = (state == ST_WR_BEAT1) ? line_q[1] : line_q[0];

	//////////////////////////////////////////////////
	// control fsm
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state       <= ST_IDLE;
			settle_cnt  <= '0;
			beat0_valid <= 1'b0;
			mc_rd_valid <= 1'b0;
		end
		else
		begin
			// single-cycle pulse
			mc_rd_valid <= 1'b0;

			case (state)
				ST_IDLE:
				begin
					if (wr_accept)
						state <= ST_WR_BEAT0;
					else if (rd_accept)
						state <= ST_RD_ISSUE;
				end

				ST_WR_BEAT0:
				begin
					state <= ST_WR_BEAT1;
				end

				ST_WR_BEAT1:
				begin
					settle_cnt <= '0;
					state      <= ST_SETTLE;
				end

				// fixed wait before the next request
				ST_SETTLE:
				begin
					if (settle_cnt == SETTLE_W'(WR_SETTLE - 1))
						state <= ST_IDLE;
					else
						settle_cnt <= settle_cnt + 1'b1;
				end

				ST_RD_ISSUE:
				begin
					state <= ST_RD_WAIT;
				end

				// first beat is low half, second completes the line
				ST_RD_WAIT:
				begin
					if (mig.rd_data_valid)
					begin
						if (!beat0_valid)
						begin
							beat0_valid <= 1'b1;
						end
						else
						begin
							beat0_valid <= 1'b0;
							mc_rd_valid <= 1'b1;
							state       <= ST_IDLE;
						end
					end
				end

				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// payload capture
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		// request payload latched at acceptance
		if (wr_accept)
			line_q <= data_wr;
		if (wr_accept || rd_accept)
			addr_q <= data_addr;

		// read assembly
		if ((state == ST_RD_WAIT) && mig.rd_data_valid)
		begin
			if (!beat0_valid)
				beat0_q <= mig.rd_data;
			else
				data_rd <= {mig.rd_data, beat0_q};
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// an accepted write pushes twice, so the margin has to cover that
	if (ddr2_pkg::AF_AFULL_MARGIN < 2)
	begin : g_margin_chk
		$error("almost-full margin below two pushes");
	end

	if (WR_SETTLE < 1)
	begin : g_settle_chk
		$error("settle needs at least one cycle");
	end

	// a line is exactly two beats on the write fifo
	a_wdf_two_beats: assert property (@(posedge clk) disable iff (rst)
		mig.wdf_wren [*2] |=> !mig.wdf_wren);

	// one completion per read
	a_rd_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		mc_rd_valid |=> !mc_rd_valid);

endmodule

// ==== mig_model/mig_fifo.sv ====
`timescale 1ns/1ps

module mig_fifo #(
	parameter type item_t = logic [7:0],
	parameter int  DEPTH  = 8
)
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        push,
	input  item_t                       push_data,
	input  logic                        pop,
	output item_t                       pop_data,
	output logic [$clog2(DEPTH+1)-1:0]  count,
	output logic                        afull
);

	localparam int PTR_W = $clog2(DEPTH);

	// storage, no reset needed
	item_t             mem [0:DEPTH-1];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;

	// head is visible without a pop
	assign pop_data = mem[rd_ptr];

	// raised with margin slots or fewer still free
	assign afull = (DEPTH - int'(count)) <= ddr2_pkg::AF_AFULL_MARGIN;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	//////////////////////////////////////////////////
	// pointers and fill level
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// explicit wrap, depth need not be a power of two
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// producers must respect afull, consumers the fill level
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		push |-> (int'(count) < DEPTH));

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		pop |-> (count != '0));

endmodule

// ==== mig_model/mig_model.sv ====
`timescale 1ns/1ps

module mig_model #(
	parameter int APPDATA_WIDTH  = 128,
	parameter int RD_LATENCY     = 4,
	parameter int MEM_LINES_LOG2 = 6,
	parameter int AF_DEPTH       = 8,
	parameter int WDF_DEPTH      = 16
)
(
	input  logic     clk,
	input  logic     rst,
	mig_user_if.mem  mig
);

	localparam int LAT_W = $clog2(RD_LATENCY + 1);

	typedef logic [APPDATA_WIDTH-1:0] beat_t;

	ddr2_pkg::af_entry_t              af_in;
	ddr2_pkg::af_entry_t              af_head;
	logic [$clog2(AF_DEPTH+1)-1:0]    af_count;
	logic                             af_pop;
	beat_t                            wdf_head;
	logic [$clog2(WDF_DEPTH+1)-1:0]   wdf_count;
	logic                             wdf_pop;

	// line memory, two beats per line, never reset
	logic [1:0][APPDATA_WIDTH-1:0]    mem [0:(1<<MEM_LINES_LOG2)-1];

	logic [MEM_LINES_LOG2-1:0]        head_idx;
	logic                             cmd_ok;

	// write in flight, high half still to store
	logic                             wr_hi_pend;
	logic [MEM_LINES_LOG2-1:0]        wr_idx;

	// read return state
	logic                             rd_busy;
	logic [LAT_W-1:0]                 lat_cnt;
	logic                             rd_beat;
	logic [MEM_LINES_LOG2-1:0]        rd_idx;

	//////////////////////////////////////////////////
	// user side fifos
	//////////////////////////////////////////////////

	assign af_in.cmd  = mig.af_cmd;
	assign af_in.addr = mig.af_addr;

	mig_fifo #(
		.item_t (ddr2_pkg::af_entry_t),
		.DEPTH  (AF_DEPTH)
	) u_af (
		.clk       (clk),
		.rst       (rst),
		.push      (mig.af_wren),
		.push_data (af_in),
		.pop       (af_pop),
		.pop_data  (af_head),
		.count     (af_count),
		.afull     (mig.af_afull)
	);

	mig_fifo #(
		.item_t (beat_t),
		.DEPTH  (WDF_DEPTH)
	) u_wdf (
		.clk       (clk),
		.rst       (rst),
		.push      (mig.wdf_wren),
		.push_data (mig.wdf_data),
		.pop       (wdf_pop),
		.pop_data  (wdf_head),
		.count     (wdf_count),
		.afull     (mig.wdf_afull)
	);

	//////////////////////////////////////////////////
	// command executor
	//////////////////////////////////////////////////

	// low address bits pick the line
	assign head_idx = af_head.addr[MEM_LINES_LOG2-1:0];

	// a write waits for both of its beats
	assign cmd_ok = (af_head.cmd == ddr2_pkg::CMD_READ) || (wdf_count >= 2);

	// one command at a time
	assign af_pop  = (af_count != '0) && cmd_ok && !rd_busy && !wr_hi_pend;
	assign wdf_pop = (af_pop && (af_head.cmd == ddr2_pkg::CMD_WRITE)) || wr_hi_pend;

	always_ff @(posedge clk)
	begin
		// low half stored in the pop cycle, high half on the next
		if (af_pop && (af_head.cmd == ddr2_pkg::CMD_WRITE))
			mem[head_idx][0] <= wdf_head;
		if (wr_hi_pend)
			mem[wr_idx][1] <= wdf_head;

		if (af_pop)
		begin
			wr_idx <= head_idx;
			rd_idx <= head_idx;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_hi_pend <= 1'b0;
			rd_busy    <= 1'b0;
			lat_cnt    <= '0;
			rd_beat    <= 1'b0;
		end
		else
		begin
			wr_hi_pend <= af_pop && (af_head.cmd == ddr2_pkg::CMD_WRITE);

			if (af_pop && (af_head.cmd == ddr2_pkg::CMD_READ))
			begin
				// first beat lands RD_LATENCY cycles after the pop
				rd_busy <= 1'b1;
				lat_cnt <= LAT_W'(RD_LATENCY - 1);
				rd_beat <= 1'b0;
			end
			else if (rd_busy)
			begin
				if (lat_cnt != '0)
				begin
					lat_cnt <= lat_cnt - 1'b1;
				end
				else
				begin
					// two back-to-back beats, then done
					rd_beat <= !rd_beat;
					if (rd_beat)
						rd_busy <= 1'b0;
				end
			end
		end
	end

	// return path
	assign mig.rd_data_valid = rd_busy && (lat_cnt == '0);
	assign mig.rd_data       = mem[rd_idx][rd_beat];

	// the next command only goes once both beats of a read are out
	a_pop_after_return: assert property (@(posedge clk) disable iff (rst)
		(af_pop && (af_head.cmd == ddr2_pkg::CMD_READ)) |=> !af_pop [*RD_LATENCY+1]);

endmodule

// ==== hw/ddr2_line_top.sv ====
`timescale 1ns/1ps

module ddr2_line_top #(
	parameter int APPDATA_WIDTH  = 128,
	parameter int WR_SETTLE      = 5,
	parameter int RD_LATENCY     = 4,
	parameter int MEM_LINES_LOG2 = 6,
	parameter int AF_DEPTH       = 8,
	parameter int WDF_DEPTH      = 16
)
(
	input  logic                             clk,
	input  logic                             rst,

	// cache side
	input  logic                             data_wren,
	input  logic                             data_rden,
	input  logic [2*APPDATA_WIDTH-1:0]       data_wr,
	input  logic [ddr2_pkg::ADDR_WIDTH-1:0]  data_addr,
	output logic                             mc_wr_rdy,
	output logic                             mc_rd_rdy,
	output logic                             mc_rd_valid,
	output logic [2*APPDATA_WIDTH-1:0]       data_rd
);

	// line port to memory controller
	mig_user_if #(
		.APPDATA_WIDTH (APPDATA_WIDTH)
	) mig_if ();

	line_port #(
		.APPDATA_WIDTH (APPDATA_WIDTH),
		.WR_SETTLE     (WR_SETTLE)
	) u_line_port (
		.clk         (clk),
		.rst         (rst),
		.data_wren   (data_wren),
		.data_rden   (data_rden),
		.data_wr     (data_wr),
		.data_addr   (data_addr),
		.mc_wr_rdy   (mc_wr_rdy),
		.mc_rd_rdy   (mc_rd_rdy),
		.mc_rd_valid (mc_rd_valid),
		.data_rd     (data_rd),
		.mig         (mig_if.ctrl)
	);

	// behavioral stand-in for the mig
	mig_model #(
		.APPDATA_WIDTH  (APPDATA_WIDTH),
		.RD_LATENCY     (RD_LATENCY),
		.MEM_LINES_LOG2 (MEM_LINES_LOG2),
		.AF_DEPTH       (AF_DEPTH),
		.WDF_DEPTH      (WDF_DEPTH)
	) u_mig_model (
		.clk (clk),
		.rst (rst),
		.mig (mig_if.mem)
	);

endmodule

// ==== test/tb_ddr2_line.sv ====
`timescale 1ns/1ps

module tb_ddr2_line;

	localparam int APPDATA_WIDTH  = 128;
	localparam int WR_SETTLE      = 5;
	localparam int MEM_LINES_LOG2 = 6;
	localparam int LINE_W         = 2 * APPDATA_WIDTH;
	localparam int ADDR_W         = ddr2_pkg::ADDR_WIDTH;
	localparam int RESET_CYCLES   = 16;
	localparam int RANDOM_OPS     = 200;
	localparam int TIMEOUT_CYCLES = RANDOM_OPS * 30 + RESET_CYCLES;
	// ready levels stay low from N+1 through N+2+WR_SETTLE
	localparam int SETTLE_LOW     = WR_SETTLE + 2;

	logic               clk;
	logic               rst;
	logic               data_wren;
	logic               data_rden;
	logic [LINE_W-1:0]  data_wr;
	logic [ADDR_W-1:0]  data_addr;
	logic               mc_wr_rdy;
	logic               mc_rd_rdy;
	logic               mc_rd_valid;
	logic [LINE_W-1:0]  data_rd;

	// acceptance as the cache sees it, write wins
	wire wr_acc = data_wren && mc_wr_rdy;
	wire rd_acc = data_rden && mc_rd_rdy && !data_wren;

	// scoreboard state
	logic [LINE_W-1:0]  sb_mem [0:(1<<MEM_LINES_LOG2)-1];
	logic [LINE_W-1:0]  exp_q [$];
	logic [LINE_W-1:0]  exp_head;
	logic [LINE_W-1:0]  wr_line_q;
	logic [ADDR_W-1:0]  req_addr_q;
	int                 pend_cnt;
	int                 n_reads;
	int                 n_pulses;

	// addresses already written, read candidates
	bit                 was_written [0:(1<<MEM_LINES_LOG2)-1];
	logic [ADDR_W-1:0]  written_q [$];

	logic [31:0]        rng_state;
	int                 cycle_cnt;
	int                 err_value;
	int                 err_proto;

	ddr2_line_top #(
		.APPDATA_WIDTH (APPDATA_WIDTH)
	) DUT (
		.clk         (clk),
		.rst         (rst),
		.data_wren   (data_wren),
		.data_rden   (data_rden),
		.data_wr     (data_wr),
		.data_addr   (data_addr),
		.mc_wr_rdy   (mc_wr_rdy),
		.mc_rd_rdy   (mc_rd_rdy),
		.mc_rd_valid (mc_rd_valid),
		.data_rd     (data_rd)
	);

	// 100 ns period
	initial clk = 1'b0;
	always #50 clk = ~clk;

	//////////////////////////////////////////////////
	// random source
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [LINE_W-1:0] rand_line();
		logic [LINE_W-1:0] v;
		for (int k = 0; k < LINE_W / 32; k++)
			v[k*32 +: 32] = next_rand();
		return v;
	endfunction

	// upper lcg bits, low ones cycle too fast
	function automatic logic [ADDR_W-1:0] rand_addr();
		logic [31:0] r;
		r = next_rand();
		return ADDR_W'(r >> (32 - MEM_LINES_LOG2));
	endfunction

	//////////////////////////////////////////////////
	// scoreboard monitor
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rst)
		begin
			exp_q.delete();
		end
		else
		begin
			// completion first, a new read can be taken on the same edge
			if (mc_rd_valid)
			begin
				n_pulses++;
				if (exp_q.size() != 0)
					void'(exp_q.pop_front());
			end
			if (wr_acc)
			begin
				sb_mem[data_addr[MEM_LINES_LOG2-1:0]] = data_wr;
				wr_line_q  = data_wr;
				req_addr_q = data_addr;
			end
			if (rd_acc)
			begin
				exp_q.push_back(sb_mem[data_addr[MEM_LINES_LOG2-1:0]]);
				req_addr_q = data_addr;
				n_reads++;
			end
		end
		pend_cnt = exp_q.size();
		exp_head = (exp_q.size() != 0) ? exp_q[0] : '0;
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_reset_hold: assert property (@(posedge clk)
		(rst && cycle_cnt > 0) |-> !mc_rd_valid)
		else
		begin
			err_proto++;
			$display("mc_rd_valid went high during reset");
		end

	a_reset_exit: assert property (@(posedge clk)
		$fell(rst) |-> (mc_wr_rdy && mc_rd_rdy && !mc_rd_valid))
		else
		begin
			err_proto++;
			$display("port not ready or read valid set on first cycle after reset");
		end

	a_settle: assert property (@(posedge clk) disable iff (rst)
		wr_acc |=> (!mc_wr_rdy && !mc_rd_rdy) [*SETTLE_LOW] ##1 (mc_wr_rdy && mc_rd_rdy))
		else
		begin
			err_proto++;
			$display("ready levels did not follow the write settle timing");
		end

	a_wr_cmd: assert property (@(posedge clk) disable iff (rst)
		wr_acc |=> (DUT.mig_if.af_wren && DUT.mig_if.af_cmd == ddr2_pkg::CMD_WRITE
			&& DUT.mig_if.af_addr == req_addr_q))
		else
		begin
			err_proto++;
			$display("accepted write issued no write command with its address");
		end

	// low half with the command, high half one edge later
	a_wr_lo: assert property (@(posedge clk) disable iff (rst)
		wr_acc |=> (DUT.mig_if.wdf_wren
			&& DUT.mig_if.wdf_data == wr_line_q[APPDATA_WIDTH-1:0]))
		else
		begin
			err_value++;
			$display("Fail write_beat_low: expected %h, actual %h",
				wr_line_q[APPDATA_WIDTH-1:0], $sampled(DUT.mig_if.wdf_data));
		end

	a_wr_hi: assert property (@(posedge clk) disable iff (rst)
		wr_acc |-> ##2 (DUT.mig_if.wdf_wren
			&& DUT.mig_if.wdf_data == wr_line_q[LINE_W-1:APPDATA_WIDTH]))
		else
		begin
			err_value++;
			$display("Fail write_beat_high: expected %h, actual %h",
				wr_line_q[LINE_W-1:APPDATA_WIDTH], $sampled(DUT.mig_if.wdf_data));
		end

	a_rd_cmd: assert property (@(posedge clk) disable iff (rst)
		rd_acc |=> (DUT.mig_if.af_wren && DUT.mig_if.af_cmd == ddr2_pkg::CMD_READ
			&& DUT.mig_if.af_addr == req_addr_q))
		else
		begin
			err_proto++;
			$display("accepted read issued no read command with its address");
		end

	a_rd_outstanding: assert property (@(posedge clk) disable iff (rst)
		mc_rd_valid |-> (pend_cnt > 0))
		else
		begin
			err_proto++;
			$display("mc_rd_valid pulse without an outstanding read");
		end

	a_rd_data: assert property (@(posedge clk) disable iff (rst)
		(mc_rd_valid && pend_cnt > 0) |-> (data_rd == exp_head))
		else
		begin
			err_value++;
			$display("Fail read_back: expected %h, actual %h",
				$sampled(exp_head), $sampled(data_rd));
		end

	a_rd_pulse: assert property (@(posedge clk) disable iff (rst)
		mc_rd_valid |=> !mc_rd_valid)
		else
		begin
			err_proto++;
			$display("mc_rd_valid held longer than one cycle");
		end

	//////////////////////////////////////////////////
	// stimulus tasks, called on a falling edge
	//////////////////////////////////////////////////

	task automatic note_written(input logic [ADDR_W-1:0] addr);
		if (!was_written[addr[MEM_LINES_LOG2-1:0]])
		begin
			was_written[addr[MEM_LINES_LOG2-1:0]] = 1'b1;
			written_q.push_back(addr);
		end
	endtask

	// hold keeps the strobe up while the port is busy
	task automatic write_line(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] line,
		input int hold);
		while (!mc_wr_rdy)
			@(negedge clk);
		data_wren = 1'b1;
		data_addr = addr;
		data_wr   = line;
		@(negedge clk);
		// payload was captured, scramble it
		data_addr = rand_addr();
		data_wr   = rand_line();
		repeat (hold) @(negedge clk);
		data_wren = 1'b0;
		note_written(addr);
	endtask

	task automatic read_line(input logic [ADDR_W-1:0] addr, input int hold);
		while (!mc_rd_rdy)
			@(negedge clk);
		data_rden = 1'b1;
		data_addr = addr;
		@(negedge clk);
		data_addr = rand_addr();
		repeat (hold) @(negedge clk);
		data_rden = 1'b0;
	endtask

	// both strobes on one edge, only the write may go
	task automatic write_read_same(input logic [ADDR_W-1:0] addr,
		input logic [LINE_W-1:0] line);
		while (!(mc_wr_rdy && mc_rd_rdy))
			@(negedge clk);
		data_wren = 1'b1;
		data_rden = 1'b1;
		data_addr = addr;
		data_wr   = line;
		@(negedge clk);
		data_wren = 1'b0;
		data_rden = 1'b0;
		note_written(addr);
	endtask

	task automatic print_counts();
		$display("error count: value %0d, protocol %0d, total %0d",
			err_value, err_proto, err_value + err_proto);
	endtask

	//////////////////////////////////////////////////
	// run limit
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles with %0d reads outstanding",
				cycle_cnt, pend_cnt);
			print_counts();
			$display("CHECKS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic [31:0]        r;
		logic [ADDR_W-1:0]  addr;
		logic [LINE_W-1:0]  line;

		rng_state = 32'h10a7067f;
		cycle_cnt = 0;
		err_value = 0;
		err_proto = 0;
		n_reads   = 0;
		n_pulses  = 0;
		rst       = 1'b1;
		data_wren = 1'b0;
		data_rden = 1'b0;
		data_wr   = '0;
		data_addr = '0;

		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// write then read back, halves differ
		for (int i = 0; i < 8; i++)
		begin
			addr = ADDR_W'((i * 9) % (1 << MEM_LINES_LOG2));
			line = rand_line();
			write_line(addr, line, 0);
			read_line(addr, 0);
		end

		// strobes held through the busy window
		write_line(ADDR_W'(3), rand_line(), 3);
		read_line(ADDR_W'(3), 3);

		// write priority, then read the new line back
		write_read_same(ADDR_W'(9), rand_line());
		read_line(ADDR_W'(9), 0);

		// random mix of back-to-back requests
		for (int n = 0; n < RANDOM_OPS; n++)
		begin
			r = next_rand();
			if (r[31])
				write_line(rand_addr(), rand_line(), int'(r[30:29]));
			else
				read_line(written_q[r[27:20] % written_q.size()], int'(r[30:29]));
		end

		// drain outstanding reads
		while (pend_cnt != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);

		if (n_reads != n_pulses)
		begin
			err_proto++;
			$display("%0d reads accepted but %0d completion pulses seen", n_reads, n_pulses);
		end

		print_counts();
		if (err_value + err_proto == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== ddr2_line.f ====
common/ddr2_pkg.sv
common/mig_user_if.sv
line_port/line_port.sv
mig_model/mig_fifo.sv
mig_model/mig_model.sv
hw/ddr2_line_top.sv
test/tb_ddr2_line.sv
